/* Makefile */
VERILATOR ?= verilator
TOP       ?= aluTb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASSMSG   ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR LOG PASSMSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* bench/aluBusy_sva.sv */
`timescale 1ns/10ps

module aluBusySva (
    input logic clk,
    input logic arstN,
    input logic launch,
    input logic busy,
    input logic rspValid,                    // bvalid or rvalid
    input logic rspReady                     // bready or rready
);

    // A response stays up until the master takes it
    assert property (@(posedge clk) disable iff (!arstN)
        rspValid && !rspReady |=> rspValid)
        else $error("response valid dropped before the matching ready");

    // Launch needs an idle unit in the cycle before
    assert property (@(posedge clk) disable iff (!arstN)
        launch |-> !$past(busy))
        else $error("operation launched while the unit was busy");

    // Busy starts with launch, so four busy cycles in a row means it did not fall in time
    assert property (@(posedge clk) disable iff (!arstN)
        !(busy && $past(busy) && $past(busy, 2) && $past(busy, 3)))
        else $error("busy still high more than three cycles after launch");

endmodule

bind aluRegFront aluBusySva uWrSva (
    .clk      (clk),
    .arstN    (arstN),
    .launch   (launch),
    .busy     (busy),
    .rspValid (wrRsp.bvalid),
    .rspReady (wrReq.bready)
);

bind aluReadBack aluBusySva uRdSva (
    .clk      (clk),
    .arstN    (arstN),
    .launch   (launch),
    .busy     (busy),
    .rspValid (rdRsp.rvalid),
    .rspReady (rdReq.rready)
);

/* bench/aluTb.sv */
`timescale 1ns/10ps

module aluTb
    import aluPkg::*;
    import axiLitePkg::*;
();

    localparam int opCount     = 160;        // Upper bound on operations launched
    localparam int cyclesPerOp = 200;
    localparam int marginCycles = 1000;
    localparam int pollLimit   = 50;

    logic        clk;
    logic        arstN;
    axiWrReqT    wrReq;
    axiWrRspT    wrRsp;
    axiRdReqT    rdReq;
    axiRdRspT    rdRsp;
    logic [31:0] mHi;                        // Model of HI
    logic [31:0] mLo;                        // Model of LO
    logic [31:0] mRes;                       // Model of regResult
    logic        resKnown;                   // Result defined by the operation rules

    clockGen uClk (.clk, .arstN);

    aluTop u_dut (.clk, .arstN, .wrReq, .rdReq, .wrRsp, .rdRsp);

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic expectEqual(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            abortRun($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, expected));
        end
    endtask

    // Called and returning on a falling edge
    task automatic axiWrite(input logic [axiAddrW-1:0] addr, input logic [31:0] data,
                            input int bDelay, output int waited);
        int n;
        waited        = 0;
        wrReq.awvalid = 1'b1;
        wrReq.awaddr  = addr;
        wrReq.wvalid  = 1'b1;
        wrReq.wdata   = data;
        wrReq.wstrb   = '1;
        while (!(wrRsp.awready && wrRsp.wready)) begin
            @(negedge clk);
            waited++;
            if (waited > pollLimit) abortRun("write address and data were never accepted");
        end
        if (addr == regOp) expectEqual("busy at regOp accept", u_dut.busy, 1'b0);
        @(negedge clk);                      // Handshake took place on the rising edge
        wrReq.awvalid = 1'b0;
        wrReq.wvalid  = 1'b0;
        n = 0;
        while (!wrRsp.bvalid) begin
            @(negedge clk);
            n++;
            if (n > pollLimit) abortRun("no write response after an accepted write");
        end
        expectEqual("bresp", wrRsp.bresp, axiRespOkay);
        repeat (bDelay) begin
            @(negedge clk);
            expectEqual("bvalid while bready low", wrRsp.bvalid, 1'b1);
        end
        wrReq.bready = 1'b1;
        @(negedge clk);
        wrReq.bready = 1'b0;
    endtask

    task automatic axiRead(input logic [axiAddrW-1:0] addr, output logic [31:0] data);
        int n;
        n             = 0;
        rdReq.arvalid = 1'b1;
        rdReq.araddr  = addr;
        while (!rdRsp.arready) begin
            @(negedge clk);
            n++;
            if (n > pollLimit) abortRun("read address was never accepted");
        end
        @(negedge clk);
        rdReq.arvalid = 1'b0;
        n = 0;
        while (!rdRsp.rvalid) begin
            @(negedge clk);
            n++;
            if (n > pollLimit) abortRun("no read data after an accepted read");
        end
        expectEqual("rresp", rdRsp.rresp, axiRespOkay);
        data         = rdRsp.rdata;
        rdReq.rready = 1'b1;
        @(negedge clk);
        rdReq.rready = 1'b0;
    endtask

    function automatic logic [31:0] aluRef(aluOpT op, logic [31:0] a, logic [31:0] b);
        logic [31:0] r;
        logic [31:0] v;
        int          n;
        r = '0;
        case (op)
            opSll:         r = b << a[4:0];  // opr1 holds the shift amount
            opSrl:         r = b >> a[4:0];
            opSra:         r = 32'($signed(b) >>> a[4:0]);
            opAdd, opAddu: r = a + b;
            opSub, opSubu: r = a - b;
            opAnd:         r = a & b;
            opOr:          r = a | b;
            opXor:         r = a ^ b;
            opNor:         r = ~(a | b);
            opSlt:         r = {31'b0, $signed(a) < $signed(b)};
            opSltu:        r = {31'b0, a < b};
            opMov:         r = a;
            opClo, opClz: begin
                v = (op == opClo) ? ~a : a;
                n = 0;
                while (n < 32 && !v[31 - n]) n++;
                r = 32'(n);
            end
            default:       r = '0;
        endcase
        return r;
    endfunction

    task automatic applyModel(input aluOpT op, input logic [31:0] a, input logic [31:0] b);
        logic [63:0] prod;
        if (op inside {opMul, opMult, opMadd, opMsub}) begin
            prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        end else begin
            prod = {32'b0, a} * {32'b0, b};
        end
        case (op)
            opMfhi:          mRes = mHi;
            opMflo:          mRes = mLo;
            opMthi:          mHi = a;
            opMtlo:          mLo = a;
            opMul:           mRes = prod[31:0];
            opMult, opMultu: {mHi, mLo} = prod;
            opMadd, opMaddu: {mHi, mLo} = {mHi, mLo} + prod;
            opMsub, opMsubu: {mHi, mLo} = {mHi, mLo} - prod;
            default:         mRes = aluRef(op, a, b);
        endcase
        if (op inside {opMthi, opMtlo}) begin
            resKnown = 1'b0;
        end else if (!(op inside {opMult, opMultu, opMadd, opMaddu, opMsub, opMsubu})) begin
            resKnown = 1'b1;
        end
    endtask

    task automatic waitIdle();
        logic [31:0] status;
        int          polls;
        polls  = 0;
        status = 32'h1;
        while (status[0]) begin
            axiRead(regStatus, status);
            polls++;
            if (polls > pollLimit) abortRun("busy never cleared after a launch");
        end
    endtask

    task automatic checkState(input string tag);
        logic [31:0] v;
        if (resKnown) begin
            axiRead(regResult, v);
            expectEqual($sformatf("regResult %s", tag), v, mRes);
        end
        axiRead(regHi, v);
        expectEqual($sformatf("regHi %s", tag), v, mHi);
        axiRead(regLo, v);
        expectEqual($sformatf("regLo %s", tag), v, mLo);
    endtask

    task automatic runOp(input aluOpT op, input logic [31:0] a, input logic [31:0] b);
        int waited;
        axiWrite(regOpr1, a, 0, waited);
        axiWrite(regOpr2, b, 0, waited);
        axiWrite(regOp, 32'(op), 0, waited);
        applyModel(op, a, b);
        waitIdle();
        checkState($sformatf("%s 0x%0h 0x%0h", op.name(), a, b));
    endtask

    task automatic testResetAndBus();
        logic [31:0]         v;
        int                  waited;
        logic [axiAddrW-1:0] holes [5];
        logic [axiAddrW-1:0] roRegs [4];
        holes  = '{regOpr1, regOpr2, 8'h1C, 8'h80, 8'hFC};
        roRegs = '{regResult, regStatus, regHi, regLo};
        checkState("after reset");
        axiRead(regStatus, v);
        expectEqual("regStatus after reset", v, 32'h0);
        axiWrite(regOpr1, 32'h1234_5678, 0, waited);
        foreach (holes[i]) begin
            axiRead(holes[i], v);
            expectEqual($sformatf("read of offset 0x%0h", holes[i]), v, 32'h0);
        end
        foreach (roRegs[i]) begin
            axiWrite(roRegs[i], 32'hDEAD_BEEF, 2, waited);    // Late bready
        end
        checkState("after read-only writes");
        axiRead(regStatus, v);
        expectEqual("regStatus after read-only writes", v, 32'h0);
        runOp(opAdd, 32'd5, 32'd7);
        axiWrite(regOp, 32'd31, 0, waited);  // Unassigned opcode
        mRes = '0;
        waitIdle();
        checkState("unknown opcode");
    endtask

    task automatic testOrdinary();
        aluOpT       ops [16];
        logic [31:0] edges [4];
        ops   = '{opSll, opSrl, opSra, opAdd, opAddu, opSub, opSubu, opAnd,
                  opOr, opXor, opNor, opSlt, opSltu, opMov, opClo, opClz};
        edges = '{32'h0000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 32'h0000_0001};
        foreach (ops[i]) begin
            for (int j = 0; j < 4; j++) begin
                runOp(ops[i], edges[j], edges[3 - j]);
            end
            repeat (3) runOp(ops[i], $urandom, $urandom);
        end
    endtask

    task automatic testMultiplies();
        logic [31:0] xs [5];
        logic [31:0] ys [5];
        logic [31:0] a;
        logic [31:0] b;
        xs = '{32'hFFFF_FFFF, 32'h8000_0000, 32'h8000_0000, 32'hFFFF_1234, 32'h7FFF_FFFF};
        ys = '{32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF, 32'h0000_ABCD, 32'hFFFF_FFFE};
        for (int i = 0; i < 8; i++) begin
            a = (i < 5) ? xs[i] : $urandom;
            b = (i < 5) ? ys[i] : $urandom;
            runOp(opMult, a, b);
            runOp(opMul, ~a, b);             // HI/LO must keep the MULT product
            runOp(opMultu, a, b);
        end
    endtask

    task automatic testAccumulate();
        runOp(opMthi, 32'h0000_0001, 32'h0);
        runOp(opMtlo, 32'hFFFF_FFF0, 32'h0);
        runOp(opMadd, 32'h8000_0000, 32'h8000_0000);
        repeat (3) begin
            runOp(opMadd, $urandom, $urandom);
            runOp(opMsubu, $urandom, $urandom);
            runOp(opMaddu, $urandom, $urandom);
        end
        runOp(opMfhi, 32'h0, 32'h0);
        runOp(opMflo, 32'h0, 32'h0);
    endtask

    task automatic testBackPressure();
        logic [31:0] a;
        logic [31:0] b;
        int          waited;
        a = $urandom;
        b = $urandom;
        axiWrite(regOpr1, a, 0, waited);
        axiWrite(regOpr2, b, 0, waited);
        axiWrite(regOp, 32'(opMult), 0, waited);
        applyModel(opMult, a, b);
        axiWrite(regOp, 32'(opMflo), 0, waited);    // Issued while the multiply runs
        applyModel(opMflo, a, b);
        expectEqual("regOp write held off by busy", waited > 1, 1'b1);
        waitIdle();
        checkState("MULT then MFLO");
    endtask

    initial begin : watchdog
        repeat (opCount * cyclesPerOp + marginCycles) @(posedge clk);
        abortRun("timeout, the tests did not finish in the allowed number of cycles");
    end

    initial begin
        wrReq    = '0;
        rdReq    = '0;
        mHi      = '0;
        mLo      = '0;
        mRes     = '0;
        resKnown = 1'b1;
        void'($urandom(6));
        wait (arstN === 1'b1);
        @(negedge clk);
        testResetAndBus();
        testOrdinary();
        testMultiplies();
        testAccumulate();
        testBackPressure();
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* bench/clockGen.sv */
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;               // 10 ns period
    end

    // Reset held low for four full cycles, released on a falling edge
    initial begin
        arstN = 1'b0;
        repeat (4) @(negedge clk);
        arstN = 1'b1;
    end

endmodule

/* compile.f */
logic/aluPkg.sv
logic/axiLitePkg.sv
logic/aluRegFront.sv
logic/aluCore.sv
logic/mulAccum.sv
logic/aluReadBack.sv
logic/aluTop.sv
bench/clockGen.sv
bench/aluBusy_sva.sv
bench/aluTb.sv

/* logic/aluCore.sv */
`timescale 1ns/10ps

module aluCore
    import aluPkg::*;
(
    input  aluReqT           req,
    input  hiloT             hilo,
    output logic [dataW-1:0] aluRes,
    output logic             resnrdy,
    output mulPartsT         mulParts
);

    logic [dataW-1:0] clzOpr;
    logic             zero16;
    logic             zero8;
    logic             zero4;
    logic [15:0]      part1;
    logic [7:0]       part2;
    logic [3:0]       part3;
    logic [1:0]       low2;
    logic [5:0]       clzCnt;
    logic [dataW-1:0] mOpr1;
    logic [dataW-1:0] mOpr2;
    logic             signedMul;

    // Leading-bit count by halving; CLO counts zeros of the inverted word
    always_comb begin
        clzOpr = (req.op == opClo) ? ~req.opr1 : req.opr1;
        zero16 = (clzOpr[31:16] == 16'b0);
        part1  = zero16 ? clzOpr[15:0] : clzOpr[31:16];
        zero8  = (part1[15:8] == 8'b0);
        part2  = zero8 ? part1[7:0] : part1[15:8];
        zero4  = (part2[7:4] == 4'b0);
        part3  = zero4 ? part2[3:0] : part2[7:4];
        casez (part3)
            4'b1???: low2 = 2'd0;
            4'b01??: low2 = 2'd1;
            4'b001?: low2 = 2'd2;
            default: low2 = 2'd3;
        endcase
        if (clzOpr == '0) begin
            clzCnt = 6'd32;                  // All bits matched
        end else begin
            clzCnt = {1'b0, zero16, zero8, zero4, low2};
        end
    end

    // Magnitudes and product sign for the multiplier
    always_comb begin
        signedMul = req.op inside {opMul, opMult, opMadd, opMsub};
        if (isMulOp(req.op)) begin
            mOpr1 = (signedMul && req.opr1[dataW-1]) ? -req.opr1 : req.opr1;
            mOpr2 = (signedMul && req.opr2[dataW-1]) ? -req.opr2 : req.opr2;
        end else begin
            mOpr1 = '0;
            mOpr2 = '0;
        end
        mulParts.neg = signedMul && (req.opr1[dataW-1] ^ req.opr2[dataW-1]);
        mulParts.op  = req.op;
        mulParts.pp0 = mOpr1[15:0]  * mOpr2[15:0];
        mulParts.pp1 = mOpr1[31:16] * mOpr2[15:0];
        mulParts.pp2 = mOpr1[15:0]  * mOpr2[31:16];
        mulParts.pp3 = mOpr1[31:16] * mOpr2[31:16];
    end

    always_comb begin
        case (req.op)
            opSll:          aluRes = req.opr2 << req.opr1[4:0];
            opSrl:          aluRes = req.opr2 >> req.opr1[4:0];
            opSra:          aluRes = $signed(req.opr2) >>> req.opr1[4:0];
            opAdd, opAddu:  aluRes = req.opr1 + req.opr2;
            opSub, opSubu:  aluRes = req.opr1 - req.opr2;
            opAnd:          aluRes = req.opr1 & req.opr2;
            opOr:           aluRes = req.opr1 | req.opr2;
            opXor:          aluRes = req.opr1 ^ req.opr2;
            opNor:          aluRes = ~(req.opr1 | req.opr2);
            opSlt:          aluRes = dataW'($signed(req.opr1) < $signed(req.opr2));
            opSltu:         aluRes = dataW'(req.opr1 < req.opr2);
            opMov, opMthi,
            opMtlo:         aluRes = req.opr1;
            opMfhi:         aluRes = hilo.hi;
            opMflo:         aluRes = hilo.lo;
            opClo, opClz:   aluRes = dataW'(clzCnt);
            default:        aluRes = '0;
        endcase
        resnrdy = isMulOp(req.op);           // Result register waits for mulAccum
    end

endmodule

/* logic/aluPkg.sv */
package aluPkg;

    localparam int dataW = 32;                   // Data word width
    localparam int opW   = 5;                    // Opcode field width

    // Unlisted codes fall to the core's default branch and give zero
    typedef enum logic [opW-1:0] {
        opSll   = 5'd0,
        opSrl   = 5'd1,
        opSra   = 5'd2,
        opAdd   = 5'd3,
        opAddu  = 5'd4,
        opSub   = 5'd5,
        opSubu  = 5'd6,
        opAnd   = 5'd7,
        opOr    = 5'd8,
        opXor   = 5'd9,
        opNor   = 5'd10,
        opSlt   = 5'd11,
        opSltu  = 5'd12,
        opMov   = 5'd13,
        opClo   = 5'd14,
        opClz   = 5'd15,
        opMfhi  = 5'd16,
        opMflo  = 5'd17,
        opMthi  = 5'd18,
        opMtlo  = 5'd19,
        opMul   = 5'd20,
        opMult  = 5'd21,
        opMultu = 5'd22,
        opMadd  = 5'd23,
        opMaddu = 5'd24,
        opMsub  = 5'd25,
        opMsubu = 5'd26
    } aluOpT;

    typedef struct packed {
        aluOpT            op;
        logic [dataW-1:0] opr1;
        logic [dataW-1:0] opr2;
    } aluReqT;

    typedef struct packed {
        logic [dataW-1:0] pp3;                   // High x high
        logic [dataW-1:0] pp2;                   // Low opr1 x high opr2
        logic [dataW-1:0] pp1;                   // High opr1 x low opr2
        logic [dataW-1:0] pp0;                   // Low x low
        logic             neg;                   // Product must be negated
        aluOpT            op;
    } mulPartsT;

    typedef struct packed {
        logic [dataW-1:0] hi;
        logic [dataW-1:0] lo;
    } hiloT;

    function automatic logic isMulOp(aluOpT op);
        return op inside {opMul, opMult, opMultu, opMadd, opMaddu, opMsub, opMsubu};
    endfunction

endpackage

/* logic/aluReadBack.sv */
`timescale 1ns/10ps

module aluReadBack
    import aluPkg::*;
    import axiLitePkg::*;
(
    input  logic             clk,
    input  logic             arstN,
    input  axiRdReqT         rdReq,
    input  logic             launch,
    input  logic             resnrdy,
    input  logic [dataW-1:0] aluRes,
    input  logic             mulDone,
    input  logic [dataW-1:0] mulResult,
    input  hiloT             hilo,
    output axiRdRspT         rdRsp,
    output logic             busy
);

    logic [dataW-1:0]    resultQ;
    logic                mulWaitQ;           // Multiply stage in flight
    logic                arreadyQ;
    logic                rvalidQ;
    logic [axiDataW-1:0] rdataQ;
    logic [axiDataW-1:0] rdMux;

    assign busy = launch || mulWaitQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mulWaitQ <= 1'b0;
            resultQ  <= '0;
        end else begin
            mulWaitQ <= launch && resnrdy;   // Fixed one-cycle multiply stage
            if (launch && !resnrdy) begin
                resultQ <= aluRes;
            end else if (mulDone) begin
                resultQ <= mulResult;
            end
        end
    end

    always_comb begin
        case (rdReq.araddr)
            regResult: rdMux = resultQ;
            regStatus: rdMux = axiDataW'(busy);
            regHi:     rdMux = hilo.hi;
            regLo:     rdMux = hilo.lo;
            default:   rdMux = '0;           // Operands and holes read zero
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            arreadyQ <= 1'b0;
            rvalidQ  <= 1'b0;
        end else if (arreadyQ && rdReq.arvalid) begin
            arreadyQ <= 1'b0;
            rvalidQ  <= 1'b1;
        end else begin
            if (rvalidQ && rdReq.rready) rvalidQ <= 1'b0;
            arreadyQ <= !rvalidQ || rdReq.rready;
        end
    end

    always_ff @(posedge clk) begin
        if (arreadyQ && rdReq.arvalid) rdataQ <= rdMux;    // Sampled at acceptance
    end

    assign rdRsp = '{arready: arreadyQ, rvalid: rvalidQ, rdata: rdataQ, rresp: axiRespOkay};

endmodule

/* logic/aluRegFront.sv */
`timescale 1ns/10ps

module aluRegFront
    import aluPkg::*;
    import axiLitePkg::*;
(
    input  logic             clk,
    input  logic             arstN,
    input  axiWrReqT         wrReq,
    input  logic             busy,
    output axiWrRspT         wrRsp,
    output logic             launch,
    output aluReqT           req,
    output logic [1:0]       hiloWr,        // Bit 1 writes HI, bit 0 writes LO
    output logic [dataW-1:0] hiloWrData
);

    logic             readyQ;                // Shared awready and wready
    logic             bvalidQ;
    logic [dataW-1:0] opr1Q;
    logic [dataW-1:0] opr2Q;
    aluOpT            opQ;
    logic             opTarget;
    logic             opStall;
    logic             wrFire;
    aluOpT            wrOp;

    assign opTarget = (wrReq.awaddr == regOp);
    assign opStall  = opTarget && busy;      // Back-pressure on a new launch
    assign wrFire   = readyQ && wrReq.awvalid && wrReq.wvalid;
    assign wrOp     = aluOpT'(wrReq.wdata[opW-1:0]);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            readyQ  <= 1'b0;
            bvalidQ <= 1'b0;
            launch  <= 1'b0;
            hiloWr  <= 2'b00;
        end else begin
            // One-cycle ready pulse, only with no response outstanding
            readyQ <= !readyQ && !bvalidQ && wrReq.awvalid && wrReq.wvalid
                      && !opStall;
            if (wrFire) begin
                bvalidQ <= 1'b1;
            end else if (wrReq.bready) begin
                bvalidQ <= 1'b0;
            end
            launch    <= wrFire && opTarget;
            hiloWr[1] <= wrFire && opTarget && (wrOp == opMthi);
            hiloWr[0] <= wrFire && opTarget && (wrOp == opMtlo);
        end
    end

    // Operand and opcode storage
    always_ff @(posedge clk) begin
        if (wrFire) begin
            for (int b = 0; b < dataW / 8; b++) begin
                if (wrReq.wstrb[b] && (wrReq.awaddr == regOpr1)) begin
                    opr1Q[8*b +: 8] <= wrReq.wdata[8*b +: 8];
                end
                if (wrReq.wstrb[b] && (wrReq.awaddr == regOpr2)) begin
                    opr2Q[8*b +: 8] <= wrReq.wdata[8*b +: 8];
                end
            end
            if (opTarget) begin
                opQ        <= wrOp;
                hiloWrData <= opr1Q;         // MTHI/MTLO source
            end
        end
    end

    assign wrRsp = '{awready: readyQ, wready: readyQ, bvalid: bvalidQ, bresp: axiRespOkay};
    assign req   = '{op: opQ, opr1: opr1Q, opr2: opr2Q};

endmodule

/* logic/aluTop.sv */
`timescale 1ns/10ps

module aluTop
    import aluPkg::*;
    import axiLitePkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  axiWrReqT wrReq,
    input  axiRdReqT rdReq,
    output axiWrRspT wrRsp,
    output axiRdRspT rdRsp
);

    logic             launch;
    logic             busy;
    logic             resnrdy;
    logic             mulDone;
    logic [1:0]       hiloWr;
    logic [dataW-1:0] hiloWrData;
    logic [dataW-1:0] aluRes;
    logic [dataW-1:0] mulResult;
    aluReqT           req;
    mulPartsT         mulParts;
    hiloT             hilo;

    aluRegFront uFront (
        .clk, .arstN, .wrReq, .busy, .wrRsp, .launch, .req, .hiloWr, .hiloWrData
    );

    aluCore uCore (
        .req, .hilo, .aluRes, .resnrdy, .mulParts
    );

    mulAccum uMul (
        .clk, .arstN, .launch, .mulParts, .hiloWr, .hiloWrData, .hilo, .mulDone, .mulResult
    );

    aluReadBack uReadBack (
        .clk, .arstN, .rdReq, .launch, .resnrdy, .aluRes, .mulDone, .mulResult, .hilo,
        .rdRsp, .busy
    );

endmodule

/* logic/axiLitePkg.sv */
package axiLitePkg;

    localparam int axiAddrW = 8;
    localparam int axiDataW = 32;

    localparam logic [1:0] axiRespOkay = 2'b00;

    // Register map
    localparam logic [axiAddrW-1:0] regOpr1   = 8'h00;
    localparam logic [axiAddrW-1:0] regOpr2   = 8'h04;
    localparam logic [axiAddrW-1:0] regOp     = 8'h08;    // Write launches the operation
    localparam logic [axiAddrW-1:0] regResult = 8'h0C;
    localparam logic [axiAddrW-1:0] regStatus = 8'h10;    // Bit 0 is busy
    localparam logic [axiAddrW-1:0] regHi     = 8'h14;
    localparam logic [axiAddrW-1:0] regLo     = 8'h18;

    typedef struct packed {
        logic                  awvalid;
        logic [axiAddrW-1:0]   awaddr;
        logic                  wvalid;
        logic [axiDataW-1:0]   wdata;
        logic [axiDataW/8-1:0] wstrb;
        logic                  bready;
    } axiWrReqT;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
    } axiWrRspT;

    typedef struct packed {
        logic                arvalid;
        logic [axiAddrW-1:0] araddr;
        logic                rready;
    } axiRdReqT;

    typedef struct packed {
        logic                arready;
        logic                rvalid;
        logic [axiDataW-1:0] rdata;
        logic [1:0]          rresp;
    } axiRdRspT;

endpackage

/* logic/mulAccum.sv */
`timescale 1ns/10ps

module mulAccum
    import aluPkg::*;
(
    input  logic             clk,
    input  logic             arstN,
    input  logic             launch,
    input  mulPartsT         mulParts,
    input  logic [1:0]       hiloWr,
    input  logic [dataW-1:0] hiloWrData,
    output hiloT             hilo,
    output logic             mulDone,        // MUL low word ready this cycle
    output logic [dataW-1:0] mulResult
);

    mulPartsT           partsQ;
    logic               stageV;
    logic [2*dataW-1:0] prodSum;
    logic [2*dataW-1:0] product;

    always_ff @(posedge clk) begin
        if (launch && isMulOp(mulParts.op)) begin
            partsQ <= mulParts;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stageV <= 1'b0;
        end else begin
            stageV <= launch && isMulOp(mulParts.op);
        end
    end

    // pp3 and pp0 do not overlap, the cross terms sit 16 bits up
    always_comb begin
        prodSum = {partsQ.pp3, partsQ.pp0}
                + {16'b0, partsQ.pp1, 16'b0}
                + {16'b0, partsQ.pp2, 16'b0};
        product   = partsQ.neg ? -prodSum : prodSum;
        mulResult = product[dataW-1:0];
        mulDone   = stageV && (partsQ.op == opMul);
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hilo <= '0;
        end else if (stageV) begin
            case (partsQ.op)
                opMult, opMultu: hilo <= hiloT'(product);
                opMadd, opMaddu: hilo <= hiloT'(hilo + product);
                opMsub, opMsubu: hilo <= hiloT'(hilo - product);
                default:         ;           // MUL keeps HI/LO
            endcase
        end else begin
            if (hiloWr[1]) hilo.hi <= hiloWrData;
            if (hiloWr[0]) hilo.lo <= hiloWrData;
        end
    end

endmodule
